// ==== design/road_params.svh ====
`ifndef ROAD_PARAMS_SVH
`define ROAD_PARAMS_SVH

// Road table RAM geometry.
// Word address width, giving 2K words per bank.
`define ROAD_AW 11

// Table and CPU data word width.
`define ROAD_DW 16

// Vertical timing points for the bank swap.
// An armed swap flips the banks on this line.
`define ROAD_SWAP_LINE 9'd475

// The arming flag drops one line later.
`define ROAD_CLEAR_LINE 9'd476

// Number of drawn scanlines.
// One table word is fetched for each.
`define ROAD_VISIBLE 9'd224

`endif

// ==== design/road_pkg.sv ====
`default_nettype none

`include "road_params.svh"

// Shared types for the road layer.
package road_pkg;

    // One table word, also the CPU data word.
    typedef logic [`ROAD_DW-1:0] road_word_t;

    // Word address into one RAM bank.
    typedef logic [`ROAD_AW-1:0] road_addr_t;

    // Byte strobes, active low.
    // Bit 0 covers the low byte.
    typedef logic [1:0] byte_strb_n_t;

    // Road mode register.
    // Table A sits at words 0 to 255, table B at 256 to 511.
    typedef enum logic [1:0] {
        road_off     = 2'd0,
        road_table_a = 2'd1,
        road_table_b = 2'd2,
        road_both    = 2'd3
    } road_mode_t;

endpackage

`default_nettype wire

// ==== design/cpu_bus_if.sv ====
`default_nettype none

// CPU bus toward the road RAM and the I/O register.
// Single cycle accesses, no handshake.
interface cpu_bus_if import road_pkg::*; ();

    // Word address and write data.
    road_addr_t   addr;
    road_word_t   wdata;
    // Active low byte strobes.
    byte_strb_n_t strb_n;
    // Chip selects for the RAM and for the I/O register.
    logic         road_cs;
    logic         io_cs;

    // CPU side.
    modport master (output addr, wdata, strb_n, road_cs, io_cs);

    // RAM banks and control register side.
    modport target (input addr, wdata, strb_n, road_cs, io_cs);

endinterface

`default_nettype wire

// ==== design/road_ctrl.sv ====
`default_nettype none

`include "road_params.svh"

// Road layer control.
// Holds the mode register, the swap arming flag and the bank select.
// Steers CPU byte writes into whichever bank the CPU currently owns.
module road_ctrl import road_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [8:0]  v,
    cpu_bus_if.target   bus,
    output logic [1:0]  we0,
    output logic [1:0]  we1,
    output logic        bank_sel,
    output road_mode_t  mode
);

    // Swap requested by the CPU, waiting for the swap line.
    logic       armed;
    // Decoded I/O register accesses.
    logic       mode_wr;
    logic       arm_req;
    // Byte lane enables before bank steering.
    logic [1:0] lane_we;
    // Vertical position decodes.
    logic       at_swap;
    logic       at_clear;

    // Strobes are active low.
    // Only cycles with the RAM chip select write anything.
    assign lane_we = {2{bus.road_cs}} & ~bus.strb_n;

    // The CPU owns the bank that bank_sel names.
    // The other one belongs to the fetch engine.
    assign we0 = bank_sel ? 2'b00 : lane_we;
    assign we1 = bank_sel ? lane_we : 2'b00;

    // Low byte write to the I/O register loads the mode.
    assign mode_wr = bus.io_cs & ~bus.strb_n[0];

    // I/O access with no strobe is a read.
    // That read arms the swap.
    assign arm_req = bus.io_cs & (bus.strb_n == 2'b11);

    assign at_swap  = (v == `ROAD_SWAP_LINE);
    assign at_clear = (v == `ROAD_CLEAR_LINE);

    // Mode register loads bits 1:0 of the data word.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= road_off;
        end else if (mode_wr) begin
            mode <= road_mode_t'(bus.wdata[1:0]);
        end
    end

    // Arming flag.
    // The clear line wins over a request in the same cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (at_clear) begin
            armed <= 1'b0;
        end else if (arm_req) begin
            armed <= 1'b1;
        end
    end

    // Bank select flips only in vertical blank.
    // The table never changes under the drawn lines.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_sel <= 1'b0;
        end else if (at_swap && armed) begin
            bank_sel <= ~bank_sel;
        end
    end

    // The CPU selects either the RAM or the I/O register in one cycle.
    a_one_chip_select: assert property (
        @(posedge clk) disable iff (rst)
        !(bus.road_cs && bus.io_cs)
    );

    // A bank swap needs the swap line and a pending arm one cycle earlier.
    a_swap_on_line_only: assert property (
        @(posedge clk) disable iff (rst)
        (bank_sel != $past(bank_sel)) |-> $past(at_swap && armed)
    );

endmodule

`default_nettype wire

// ==== design/road_ram_bank.sv ====
`default_nettype none

`include "road_params.svh"

// One road table bank.
// Dual port RAM, CPU port with byte writes, engine port read only.
// Both read ports are registered.
module road_ram_bank import road_pkg::*; (
    input  logic        clk,
    cpu_bus_if.target   bus,
    input  logic [1:0]  we,
    output road_word_t  cpu_q,
    input  road_addr_t  eng_addr,
    output road_word_t  eng_q
);

    // Bank depth and the byte lane split.
    localparam int DEPTH = 2 ** `ROAD_AW;
    localparam int HALF  = `ROAD_DW / 2;

    // Table storage.
    road_word_t mem [DEPTH];

    // CPU port.
    // Each lane writes on its own enable.
    // Read returns the old word during a write to the same address.
    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem[bus.addr][HALF-1:0] <= bus.wdata[HALF-1:0];
        end
        if (we[1]) begin
            mem[bus.addr][`ROAD_DW-1:HALF] <= bus.wdata[`ROAD_DW-1:HALF];
        end
        cpu_q <= mem[bus.addr];
    end

    // Engine port, one read per cycle.
    always_ff @(posedge clk) begin
        eng_q <= mem[eng_addr];
    end

    // Once the fetch engine drives a known address it never goes unknown.
    a_eng_addr_known: assert property (
        @(posedge clk)
        !$isunknown($past(eng_addr)) |-> !$isunknown(eng_addr)
    );

endmodule

`default_nettype wire

// ==== design/road_fetch.sv ====
`default_nettype none

`include "road_params.svh"

// Road line fetch engine.
// Reads one table word per visible scanline from the engine bank.
// Edge 0 samples the new line and drives eng_addr.
// Edge 1 is the RAM read, edge 2 updates line_data with line_valid.
module road_fetch import road_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [8:0]  v,
    input  logic        bank_sel,
    input  road_mode_t  mode,
    output road_addr_t  eng_addr,
    input  road_word_t  eng_q0,
    input  road_word_t  eng_q1,
    output road_word_t  line_data,
    output logic        line_valid
);

    // Table B starts half way into the first 512 words.
    localparam road_addr_t TABLE_B_BASE = road_addr_t'(256);

    // Previous line, to spot the change of v.
    logic [8:0] v_q;
    // Low for the first cycle after reset, so a steady v does not fetch.
    logic       primed;
    logic       new_line;
    // Table address for the current line.
    road_addr_t line_a;
    road_addr_t line_addr;
    // Request stage, edge 0.
    road_addr_t addr_q;
    logic       req_valid;
    road_mode_t req_mode;
    logic       req_bank;
    // RAM read stage, edge 1.
    logic       rd_valid;
    road_mode_t rd_mode;
    logic       rd_bank;

    assign new_line = primed && (v != v_q) && (v < `ROAD_VISIBLE);

    // Line number as a table A word address.
    assign line_a = road_addr_t'(v);

    // Address from line and mode.
    // Off mode still reads, the data is dropped later.
    always_comb begin
        case (mode)
            road_table_b: line_addr = line_a + TABLE_B_BASE;
            road_both:    line_addr = v[0] ? line_a + TABLE_B_BASE : line_a;
            default:      line_addr = line_a;
        endcase
    end

    assign eng_addr = addr_q;

    // Edge 0. Mode and bank travel with the request.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v_q       <= '0;
            primed    <= 1'b0;
            req_valid <= 1'b0;
            addr_q    <= '0;
            req_mode  <= road_off;
            req_bank  <= 1'b0;
        end else begin
            v_q       <= v;
            primed    <= 1'b1;
            req_valid <= new_line;
            if (new_line) begin
                addr_q   <= line_addr;
                req_mode <= mode;
                // The engine owns the bank the CPU does not.
                req_bank <= ~bank_sel;
            end
        end
    end

    // Edge 1 (RAM registers its data alongside).
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_mode  <= road_off;
            rd_bank  <= 1'b0;
        end else begin
            rd_valid <= req_valid;
            rd_mode  <= req_mode;
            rd_bank  <= req_bank;
        end
    end

    // Edge 2. Pick the engine bank, zero when the road is off.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_valid <= 1'b0;
            line_data  <= '0;
        end else begin
            line_valid <= rd_valid;
            if (rd_valid) begin
                if (rd_mode == road_off) begin
                    line_data <= '0;
                end else begin
                    line_data <= rd_bank ? eng_q1 : eng_q0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/road_subsystem.sv ====
`default_nettype none

// Road layer memory and control.
// Two table banks, the control registers and the line fetch engine.
module road_subsystem import road_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic [8:0]   v,
    // CPU bus.
    input  road_addr_t   cpu_addr,
    input  road_word_t   cpu_dout,
    input  byte_strb_n_t cpu_dswn,
    input  logic         road_cs,
    input  logic         io_cs,
    output road_word_t   cpu_din,
    // Road line descriptor.
    output road_word_t   line_data,
    output logic         line_valid
);

    // Bus shared by the controller and both banks.
    cpu_bus_if bus ();

    // Per-bank byte write enables.
    logic [1:0] we0;
    logic [1:0] we1;
    // Bank owned by the CPU.
    logic       bank_sel;
    road_mode_t mode;
    // Engine side.
    road_addr_t eng_addr;
    road_word_t eng_q0;
    road_word_t eng_q1;
    // CPU read data from each bank.
    road_word_t cpu_q0;
    road_word_t cpu_q1;

    assign bus.addr    = cpu_addr;
    assign bus.wdata   = cpu_dout;
    assign bus.strb_n  = cpu_dswn;
    assign bus.road_cs = road_cs;
    assign bus.io_cs   = io_cs;

    // CPU reads come from its own bank.
    assign cpu_din = bank_sel ? cpu_q1 : cpu_q0;

    road_ctrl ctrl_inst (
        .clk      (clk),
        .rst      (rst),
        .v        (v),
        .bus      (bus),
        .we0      (we0),
        .we1      (we1),
        .bank_sel (bank_sel),
        .mode     (mode)
    );

    road_ram_bank bank0_inst (
        .clk      (clk),
        .bus      (bus),
        .we       (we0),
        .cpu_q    (cpu_q0),
        .eng_addr (eng_addr),
        .eng_q    (eng_q0)
    );

    road_ram_bank bank1_inst (
        .clk      (clk),
        .bus      (bus),
        .we       (we1),
        .cpu_q    (cpu_q1),
        .eng_addr (eng_addr),
        .eng_q    (eng_q1)
    );

    road_fetch fetch_inst (
        .clk        (clk),
        .rst        (rst),
        .v          (v),
        .bank_sel   (bank_sel),
        .mode       (mode),
        .eng_addr   (eng_addr),
        .eng_q0     (eng_q0),
        .eng_q1     (eng_q1),
        .line_data  (line_data),
        .line_valid (line_valid)
    );

endmodule

`default_nettype wire

// ==== tb/tb_road_subsystem.sv ====
`default_nettype none

`include "road_params.svh"

// Testbench for the road layer subsystem.
// Commands and expected values come from tb/road_patterns.txt.
module tb_road_subsystem import road_pkg::*; ();

    logic         clk;
    logic         rst;
    logic [8:0]   v;
    road_addr_t   cpu_addr;
    road_word_t   cpu_dout;
    byte_strb_n_t cpu_dswn;
    logic         road_cs;
    logic         io_cs;
    road_word_t   cpu_din;
    road_word_t   line_data;
    logic         line_valid;

    // Pattern commands with one entry per file line.
    string cmd_op[$];
    int    cmd_a[$];
    int    cmd_b[$];
    int    cmd_s[$];
    string cmd_exp[$];

    // Scoreboard model of both banks and the control state.
    road_word_t model_mem [2][1 << `ROAD_AW];
    logic       model_sel;
    logic       model_armed;
    road_mode_t model_mode;

    int     pass_count;
    int     fail_count;
    int     limit;
    logic   loaded;
    integer seed;

    road_subsystem road_subsystem_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog sized from the pattern count once the file is read.
    initial begin
        wait (loaded);
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles with the patterns still running", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_word(input string name, input road_word_t exp, input road_word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            fail_count++;
        end else begin
            $display("[PASS] %s read %h", name, act);
            pass_count++;
        end
    endtask

    task automatic check_line(input string name, input road_word_t exp, input logic exp_valid,
                              input road_word_t act, input logic act_valid);
        if (act_valid !== exp_valid || act !== exp) begin
            $display("[FAIL] %s expected %h valid %b actual %h valid %b",
                     name, exp, exp_valid, act, act_valid);
            fail_count++;
        end else begin
            $display("[PASS] %s line %h valid %b", name, act, act_valid);
            pass_count++;
        end
    endtask

    // Text column to expected word.
    function automatic road_word_t pick_expected(input string text, input road_word_t model_val);
        road_word_t val;
        int         code;
        val = model_val;
        if (text != "model") begin
            code = $sscanf(text, "%h", val);
            if (code != 1) begin
                $display("Expected value %s in the pattern file is not a hex word", text);
                fail_count++;
            end
        end
        return val;
    endfunction

    // Descriptor the model predicts for a line.
    // Table B sits 256 words above table A. Mode both uses B on odd lines.
    function automatic road_word_t expect_line(input int line);
        road_addr_t addr;
        addr = road_addr_t'(line);
        if (model_mode == road_table_b || (model_mode == road_both && line % 2 == 1)) begin
            addr = addr + road_addr_t'(256);
        end
        if (model_mode == road_off) return '0;
        return model_mem[~model_sel][addr];
    endfunction

    task automatic bus_write(input road_addr_t addr, input road_word_t data,
                             input byte_strb_n_t strb_n);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_dout <= data;
        cpu_dswn <= strb_n;
        road_cs  <= 1'b1;
        @(posedge clk);
        road_cs  <= 1'b0;
        cpu_dswn <= 2'b11;
        // Low strobe writes its lane in the CPU bank.
        if (!strb_n[0]) model_mem[model_sel][addr][7:0] = data[7:0];
        if (!strb_n[1]) model_mem[model_sel][addr][15:8] = data[15:8];
    endtask

    task automatic bus_read(input road_addr_t addr, output road_word_t data);
        @(posedge clk);
        cpu_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = cpu_din;
    endtask

    task automatic io_access(input byte_strb_n_t strb_n, input road_word_t data);
        @(posedge clk);
        cpu_dout <= data;
        cpu_dswn <= strb_n;
        io_cs    <= 1'b1;
        @(posedge clk);
        io_cs    <= 1'b0;
        cpu_dswn <= 2'b11;
    endtask

    // Walk v through blanking past the swap and clear lines.
    task automatic step_frame();
        for (int l = int'(`ROAD_VISIBLE); l <= int'(`ROAD_CLEAR_LINE) + 4; l++) begin
            @(posedge clk);
            v <= 9'(l);
        end
        if (model_armed) model_sel = ~model_sel;
        model_armed = 1'b0;
    endtask

    // Move v to a line and wait for the descriptor.
    task automatic fetch_line(input int line, output road_word_t data, output logic valid,
                              output int edges);
        // Same line again needs a step away so the DUT sees a change.
        if (v == 9'(line)) begin
            @(posedge clk);
            v <= 9'h1ff;
        end
        @(posedge clk);
        v <= 9'(line);
        edges = 0;
        valid = 1'b0;
        data  = '0;
        while (!valid && edges < 8) begin
            @(posedge clk);
            @(negedge clk);
            edges++;
            valid = line_valid;
            data  = line_data;
        end
    endtask

    task automatic load_patterns(output logic ok);
        int    fd;
        int    code;
        int    ch;
        int    a;
        int    b;
        int    s;
        string op;
        string e;
        fd = $fopen("tb/road_patterns.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code == 1 && op.getc(0) == "#") begin
                // Skip the rest of a comment line.
                ch = 0;
                while (ch != 10 && ch != -1) ch = $fgetc(fd);
            end else if (code == 1) begin
                code = $fscanf(fd, "%h %h %h %s", a, b, s, e);
                cmd_op.push_back(op);
                cmd_a.push_back(a);
                cmd_b.push_back(b);
                cmd_s.push_back(s);
                cmd_exp.push_back(e);
            end
        end
        if (ok) $fclose(fd);
    endtask

    task automatic run_command(input int idx);
        string      name;
        string      op;
        road_word_t got;
        road_word_t exp;
        logic       got_valid;
        int         edges;
        int         a;
        op   = cmd_op[idx];
        a    = cmd_a[idx];
        name = $sformatf("%0d %s %0h", idx, op, a);
        case (op)
            "write": bus_write(road_addr_t'(a), road_word_t'(cmd_b[idx]),
                               byte_strb_n_t'(cmd_s[idx]));
            "read": begin
                bus_read(road_addr_t'(a), got);
                exp = pick_expected(cmd_exp[idx], model_mem[model_sel][road_addr_t'(a)]);
                check_word(name, exp, got);
            end
            "mode": begin
                io_access(2'b10, road_word_t'(a));
                model_mode = road_mode_t'(a[1:0]);
            end
            "swap": begin
                // I/O read with both strobes high arms the swap.
                io_access(2'b11, '0);
                model_armed = 1'b1;
                step_frame();
            end
            "frame": step_frame();
            "line": begin
                exp = pick_expected(cmd_exp[idx], expect_line(a));
                fetch_line(a, got, got_valid, edges);
                check_line(name, exp, 1'b1, got, got_valid);
                // Edge 0 plus two more edges.
                if (got_valid && edges != 3) begin
                    $display("[ERROR] %s descriptor came %0d cycles after the line change",
                             name, edges - 1);
                    fail_count++;
                end
            end
            "idle": begin
                got_valid = 1'b0;
                repeat (a) begin
                    @(posedge clk);
                    @(negedge clk);
                    got_valid = got_valid | line_valid;
                end
                check_line(name, '0, 1'b0, line_data, got_valid);
            end
            "rand": begin
                for (int i = 0; i < cmd_b[idx]; i++) begin
                    bus_write(road_addr_t'(a + i), road_word_t'($random(seed)), 2'b00);
                end
            end
            default: begin
                $display("[ERROR] %s is not a known pattern command", name);
                fail_count++;
            end
        endcase
    endtask

    initial begin
        logic ok;
        rst         = 1'b1;
        v           = '0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        cpu_dswn    = 2'b11;
        road_cs     = 1'b0;
        io_cs       = 1'b0;
        model_sel   = 1'b0;
        model_armed = 1'b0;
        model_mode  = road_off;
        pass_count  = 0;
        fail_count  = 0;
        loaded      = 1'b0;
        seed        = 32'hfd7a;
        load_patterns(ok);
        if (!ok) begin
            $display("Pattern file tb/road_patterns.txt could not be opened");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            // A swap walks up to a whole frame of lines.
            limit  = 20 * cmd_op.size() * 600;
            loaded = 1'b1;
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            foreach (cmd_op[i]) run_command(i);
            repeat (4) @(posedge clk);
            $display("Tests done: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/road_pkg.sv
design/cpu_bus_if.sv
design/road_ctrl.sv
design/road_ram_bank.sv
design/road_fetch.sv
design/road_subsystem.sv
tb/tb_road_subsystem.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_road_subsystem \
    > sim.log 2>&1 \
    && ./obj_dir/Vtb_road_subsystem >> sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log \
    && echo "Road subsystem run passed" \
    || { echo "Road subsystem run failed, see sim.log"; exit 1; }

// ==== tb/road_patterns.txt ====
# op     a      b      strb_n  expected
# a/b/strb_n in hex. expected is a hex word, model for the scoreboard, or - when unused.
idle     8      0      3       -
line     3      0      3       0000
write    3      a5a5   0       -
write    4      1234   0       -
write    103    5a5a   0       -
read     4      0      3       1234
write    4      ff77   2       -
write    4      ab00   1       -
read     4      0      3       ab77
frame    0      0      3       -
read     3      0      3       a5a5
mode     1      0      3       -
swap     0      0      3       -
line     3      0      3       a5a5
mode     2      0      3       -
line     3      0      3       5a5a
mode     3      0      3       -
line     4      0      3       ab77
write    3      0f0f   0       -
mode     1      0      3       -
line     3      0      3       a5a5
swap     0      0      3       -
line     3      0      3       0f0f
read     3      0      3       a5a5
rand     10     8      3       -
rand     110    8      3       -
swap     0      0      3       -
mode     3      0      3       -
line     11     0      3       model
line     12     0      3       model
rand     10     8      3       -
line     13     0      3       model
swap     0      0      3       -
mode     1      0      3       -
line     11     0      3       model
line     12     0      3       model
read     13     0      3       model
